/* bench/frame_buffer_assert.sv */
/*
 * Protocol checks on the frame reader
 * SRAM port direction during readout and output stream framing
 */
`timescale 1ns/1ps

module frame_buffer_assert (
  input logic clk_i,
  input logic rst_n_i,
  input logic busy_i,
  input logic wr_req_i,
  input logic mem_req_i,
  input logic mem_we_i,
  input logic word_valid_i,
  input logic word_last_i
);

  // Number of failed checks, read back by the testbench
  int fail_count = 0;

  // Reader owns the port, so a writer request here would be lost
  no_write_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_i |-> !wr_req_i)
    else begin
      fail_count++;
      $error("Writer requested an SRAM write during readout");
    end

  // Read data comes back exactly one cycle later
  valid_after_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_i && !mem_we_i) |=> word_valid_i)
    else begin
      fail_count++;
      $error("SRAM read not followed by an output word");
    end

  valid_has_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    word_valid_i |-> $past(mem_req_i && !mem_we_i))
    else begin
      fail_count++;
      $error("Output word without a read one cycle earlier");
    end

  last_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    word_last_i |-> word_valid_i)
    else begin
      fail_count++;
      $error("Last marker without a valid word");
    end

endmodule

/* bench/frame_buffer_tb.sv */
/*
 * Testbench for the frame buffer
 * Random frames in, words checked against a reference model
 */
`timescale 1ns/1ps

module frame_buffer_tb;

  import mem_pkg::*;
  import frame_pkg::*;

  localparam int N_FRAMES       = 40;
  localparam int TIMEOUT_CYCLES = N_FRAMES * 400;

  logic                      clk;
  logic                      rst_n;
  logic                      byte_valid;
  logic [MEM_BYTE_WIDTH-1:0] byte_data;
  logic                      byte_last;
  logic                      ready;
  logic                      word_valid;
  logic [MEM_DATA_WIDTH-1:0] word_data;
  logic [MEM_STRB_WIDTH-1:0] word_be;
  logic                      word_last;

  logic [MEM_BYTE_WIDTH-1:0] frame_bytes [FRAME_MAX_BYTES];
  logic [MEM_DATA_WIDTH-1:0] exp_data [$];
  logic [MEM_STRB_WIDTH-1:0] exp_be [$];
  logic                      exp_last [$];
  logic [MEM_DATA_WIDTH-1:0] cur_data;
  logic [MEM_STRB_WIDTH-1:0] cur_be;
  logic                      cur_last;

  int cycle          = 0;
  int frames_checked = 0;
  int first_due      = -1;
  int holdoff_start  = 0;
  logic in_frame     = 1'b0;
  logic holdoff      = 1'b0;

  frame_buffer_top dut0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .byte_valid_i (byte_valid),
    .byte_data_i  (byte_data),
    .byte_last_i  (byte_last),
    .ready_o      (ready),
    .word_valid_o (word_valid),
    .word_data_o  (word_data),
    .word_be_o    (word_be),
    .word_last_o  (word_last)
  );

  bind frame_reader frame_buffer_assert reader_assert0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .busy_i       (busy_o),
    .wr_req_i     (wr_req_i),
    .mem_req_i    (mem_req_o),
    .mem_we_i     (mem_we_o),
    .word_valid_i (word_valid_o),
    .word_last_i  (word_last_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  // Expected words of the frame in frame_bytes, little endian lanes
  function automatic void build_expected(input int len);
    int n_words;
    logic [MEM_DATA_WIDTH-1:0] data;
    logic [MEM_STRB_WIDTH-1:0] be;
    n_words = (len + MEM_STRB_WIDTH - 1) / MEM_STRB_WIDTH;
    for (int w = 0; w < n_words; w++) begin
      data = '0;
      be   = '0;
      for (int l = 0; l < MEM_STRB_WIDTH; l++) begin
        if (w * MEM_STRB_WIDTH + l < len) begin
          data[l*MEM_BYTE_WIDTH +: MEM_BYTE_WIDTH] = frame_bytes[w * MEM_STRB_WIDTH + l];
          be[l] = 1'b1;
        end
      end
      exp_data.push_back(data);
      exp_be.push_back(be);
      exp_last.push_back(w == n_words - 1);
    end
  endfunction

  function automatic logic [MEM_DATA_WIDTH-1:0] lane_bits(input logic [MEM_STRB_WIDTH-1:0] be);
    logic [MEM_DATA_WIDTH-1:0] bits;
    for (int l = 0; l < MEM_STRB_WIDTH; l++) begin
      bits[l*MEM_BYTE_WIDTH +: MEM_BYTE_WIDTH] = {MEM_BYTE_WIDTH{be[l]}};
    end
    return bits;
  endfunction

  // Directed lengths first: extremes and every tail size
  function automatic int frame_length(input int f);
    case (f)
      0:       return 1;
      1:       return FRAME_MAX_BYTES;
      2:       return 8;
      3:       return 13;
      4:       return 18;
      5:       return 23;
      default: return $urandom_range(1, FRAME_MAX_BYTES);
    endcase
  endfunction

  task automatic send_frame(input int len);
    for (int k = 0; k < len; k++) begin
      repeat ($urandom_range(0, 2)) begin
        @(posedge clk);
        #1;
      end
      while (!ready) begin
        @(posedge clk);
        #1;
      end
      byte_valid = 1'b1;
      byte_data  = frame_bytes[k];
      byte_last  = (k == len - 1);
      @(posedge clk);
      #1;
      byte_valid = 1'b0;
      byte_last  = 1'b0;
    end
  endtask

  initial begin
    int len;
    void'($urandom(96926));
    rst_n      = 1'b0;
    byte_valid = 1'b0;
    byte_data  = '0;
    byte_last  = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    for (int f = 0; f < N_FRAMES; f++) begin
      len = frame_length(f);
      for (int k = 0; k < len; k++) begin
        frame_bytes[k] = MEM_BYTE_WIDTH'($urandom);
      end
      build_expected(len);
      send_frame(len);
    end
    wait (frames_checked == N_FRAMES);
    @(posedge clk);
    #1;
    if (dut0.reader0.reader_assert0.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d frames checked", cycle, frames_checked);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  // Checks run mid-cycle where every signal is settled
  always @(negedge clk) begin
    if (rst_n) begin
      assert (dut0.reader0.reader_assert0.fail_count == 0)
        else stop_on_error("A bound protocol assertion on the reader failed");
      if (byte_valid && ready && byte_last) begin
        first_due     = cycle + 3;
        holdoff_start = cycle + 1;
        holdoff       = 1'b1;
      end
      if (holdoff && cycle >= holdoff_start) begin
        assert (!ready) else stop_on_error("Input ready was high during flush or readout");
      end
      if (word_valid) begin
        assert (exp_data.size() > 0) else stop_on_error("Output word with no frame pending");
        if (!in_frame) begin
          assert (cycle == first_due)
            else stop_on_error("First output word did not arrive 3 cycles after last byte");
        end
        cur_data = exp_data.pop_front();
        cur_be   = exp_be.pop_front();
        cur_last = exp_last.pop_front();
        assert (word_be === cur_be)
          else stop_on_error($sformatf("ERROR word_be_o: got 0x%h expected 0x%h",
                                       word_be, cur_be));
        assert ((word_data & lane_bits(cur_be)) === cur_data)
          else stop_on_error($sformatf("ERROR word_data_o: got 0x%h expected 0x%h",
                                       word_data & lane_bits(cur_be), cur_data));
        assert (word_last === cur_last)
          else stop_on_error($sformatf("ERROR word_last_o: got 0x%h expected 0x%h",
                                       word_last, cur_last));
        in_frame = !cur_last;
        if (cur_last) begin
          holdoff = 1'b0;
          frames_checked++;
        end
      end else begin
        assert (!in_frame) else stop_on_error("Output words of a frame were not back to back");
      end
    end
  end

endmodule

/* compile.f */
design/mem_pkg.sv
design/frame_pkg.sv
design/sram.sv
design/frame_writer.sv
design/frame_reader.sv
design/frame_buffer_top.sv
bench/frame_buffer_assert.sv
bench/frame_buffer_tb.sv

/* design/frame_buffer_top.sv */
/*
 * Frame buffer top level
 * Writer, SRAM and reader around one stored frame
 */
`timescale 1ns/1ps

module frame_buffer_top (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               byte_valid_i,
  input  logic [mem_pkg::MEM_BYTE_WIDTH-1:0] byte_data_i,
  input  logic                               byte_last_i,
  output logic                               ready_o,
  output logic                               word_valid_o,
  output logic [mem_pkg::MEM_DATA_WIDTH-1:0] word_data_o,
  output logic [mem_pkg::MEM_STRB_WIDTH-1:0] word_be_o,
  output logic                               word_last_o
);

  import mem_pkg::*;
  import frame_pkg::*;

  // Writer requests
  logic                       wr_req;
  logic [MEM_ADDR_WIDTH-1:0]  wr_addr;
  logic [MEM_DATA_WIDTH-1:0]  wr_wdata;
  logic [MEM_STRB_WIDTH-1:0]  wr_be;
  logic                       frame_done;
  logic [FRAME_LEN_WIDTH-1:0] frame_len;
  logic                       busy;

  // Actual SRAM port
  logic                       mem_req;
  logic                       mem_we;
  logic [MEM_ADDR_WIDTH-1:0]  mem_addr;
  logic [MEM_DATA_WIDTH-1:0]  mem_wdata;
  logic [MEM_STRB_WIDTH-1:0]  mem_be;
  logic [MEM_DATA_WIDTH-1:0]  mem_rdata;

  // ready_o already folds in busy
  frame_writer writer0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .byte_valid_i (byte_valid_i),
    .byte_data_i  (byte_data_i),
    .byte_last_i  (byte_last_i),
    .busy_i       (busy),
    .ready_o      (ready_o),
    .wr_req_o     (wr_req),
    .wr_addr_o    (wr_addr),
    .wr_wdata_o   (wr_wdata),
    .wr_be_o      (wr_be),
    .frame_done_o (frame_done),
    .frame_len_o  (frame_len)
  );

  sram sram0 (
    .clk_i   (clk_i),
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .be_i    (mem_be),
    .rdata_o (mem_rdata)
  );

  frame_reader reader0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .frame_done_i (frame_done),
    .frame_len_i  (frame_len),
    .wr_req_i     (wr_req),
    .wr_addr_i    (wr_addr),
    .wr_wdata_i   (wr_wdata),
    .wr_be_i      (wr_be),
    .busy_o       (busy),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_be_o     (mem_be),
    .mem_rdata_i  (mem_rdata),
    .word_valid_o (word_valid_o),
    .word_data_o  (word_data_o),
    .word_be_o    (word_be_o),
    .word_last_o  (word_last_o)
  );

endmodule

/* design/frame_pkg.sv */
/*
 * Frame level definitions
 * Length limits and the reader FSM state encoding
 */
package frame_pkg;

  // A frame fills at most the whole SRAM
  localparam int unsigned FRAME_MAX_BYTES =
    mem_pkg::MEM_N_WORDS * mem_pkg::MEM_STRB_WIDTH;

  // Byte count must hold FRAME_MAX_BYTES itself
  localparam int unsigned FRAME_LEN_WIDTH = $clog2(FRAME_MAX_BYTES + 1);

  // Word count of a frame, up to MEM_N_WORDS inclusive
  localparam int unsigned FRAME_WORD_CNT_WIDTH =
    FRAME_LEN_WIDTH - mem_pkg::MEM_LANE_WIDTH;

  // Reader FSM
  typedef enum logic [1:0] {
    READ_IDLE,
    READ_ISSUE,
    READ_DRAIN
  } reader_state_e;

endpackage

/* design/frame_reader.sv */
/*
 * Frame reader
 * Muxes the SRAM port and replays a stored frame as a masked word stream
 */
`timescale 1ns/1ps

module frame_reader (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  frame_done_i,
  input  logic [frame_pkg::FRAME_LEN_WIDTH-1:0] frame_len_i,
  input  logic                                  wr_req_i,
  input  logic [mem_pkg::MEM_ADDR_WIDTH-1:0]    wr_addr_i,
  input  logic [mem_pkg::MEM_DATA_WIDTH-1:0]    wr_wdata_i,
  input  logic [mem_pkg::MEM_STRB_WIDTH-1:0]    wr_be_i,
  output logic                                  busy_o,
  output logic                                  mem_req_o,
  output logic                                  mem_we_o,
  output logic [mem_pkg::MEM_ADDR_WIDTH-1:0]    mem_addr_o,
  output logic [mem_pkg::MEM_DATA_WIDTH-1:0]    mem_wdata_o,
  output logic [mem_pkg::MEM_STRB_WIDTH-1:0]    mem_be_o,
  input  logic [mem_pkg::MEM_DATA_WIDTH-1:0]    mem_rdata_i,
  output logic                                  word_valid_o,
  output logic [mem_pkg::MEM_DATA_WIDTH-1:0]    word_data_o,
  output logic [mem_pkg::MEM_STRB_WIDTH-1:0]    word_be_o,
  output logic                                  word_last_o
);

  import mem_pkg::*;
  import frame_pkg::*;

  reader_state_e                   state_q;
  logic [FRAME_WORD_CNT_WIDTH-1:0] words_left_q;
  logic [MEM_ADDR_WIDTH-1:0]       rd_addr_q;
  logic [MEM_STRB_WIDTH-1:0]       last_be_q;
  logic [FRAME_LEN_WIDTH-1:0]      len_round;
  logic [FRAME_WORD_CNT_WIDTH-1:0] len_words;
  logic [MEM_LANE_WIDTH-1:0]       len_tail;
  logic [MEM_STRB_WIDTH-1:0]       tail_be;
  logic                            issue;
  logic                            final_rd;
  logic                            out_valid_q;
  logic                            out_last_q;
  logic [MEM_STRB_WIDTH-1:0]       out_be_q;

  // Words in the frame, rounded up
  assign len_round = frame_len_i + FRAME_LEN_WIDTH'(MEM_STRB_WIDTH - 1);
  assign len_words = len_round[FRAME_LEN_WIDTH-1:MEM_LANE_WIDTH];
  assign len_tail  = frame_len_i[MEM_LANE_WIDTH-1:0];

  // Low lanes of a partial last word, all lanes for a full one
  always_comb begin
    tail_be = '1;
    if (len_tail != '0) begin
      tail_be = (MEM_STRB_WIDTH'(1) << len_tail) - 1'b1;
    end
  end

  assign issue    = (state_q == READ_ISSUE);
  assign final_rd = issue & (words_left_q == FRAME_WORD_CNT_WIDTH'(1));
  assign busy_o   = (state_q != READ_IDLE);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= READ_IDLE;
      words_left_q <= '0;
      rd_addr_q    <= '0;
    end else begin
      case (state_q)
        READ_IDLE: begin
          if (frame_done_i) begin
            state_q      <= READ_ISSUE;
            words_left_q <= len_words;
            rd_addr_q    <= '0;
          end
        end
        READ_ISSUE: begin
          rd_addr_q    <= rd_addr_q + 1'b1;
          words_left_q <= words_left_q - 1'b1;
          if (final_rd) begin
            state_q <= READ_DRAIN;
          end
        end
        // Last word is on the output this cycle
        READ_DRAIN: state_q <= READ_IDLE;
        default:    state_q <= READ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == READ_IDLE) && frame_done_i) begin
      last_be_q <= tail_be;
    end
    out_be_q <= final_rd ? last_be_q : '1;
  end

  // Tags travel alongside the read in flight
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
      out_last_q  <= 1'b0;
    end else begin
      out_valid_q <= issue;
      out_last_q  <= final_rd;
    end
  end

  // SRAM port belongs to the writer unless a readout is running
  assign mem_req_o   = busy_o ? issue : wr_req_i;
  assign mem_we_o    = ~busy_o;
  assign mem_addr_o  = busy_o ? rd_addr_q : wr_addr_i;
  assign mem_wdata_o = wr_wdata_i;
  assign mem_be_o    = busy_o ? '0 : wr_be_i;

  assign word_valid_o = out_valid_q;
  assign word_data_o  = mem_rdata_i;
  assign word_be_o    = out_be_q;
  assign word_last_o  = out_last_q;

endmodule

/* design/frame_writer.sv */
/*
 * Frame writer
 * Packs the input byte stream little endian into words and writes them to the SRAM
 */
`timescale 1ns/1ps

module frame_writer (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 byte_valid_i,
  input  logic [mem_pkg::MEM_BYTE_WIDTH-1:0]   byte_data_i,
  input  logic                                 byte_last_i,
  input  logic                                 busy_i,
  output logic                                 ready_o,
  output logic                                 wr_req_o,
  output logic [mem_pkg::MEM_ADDR_WIDTH-1:0]   wr_addr_o,
  output logic [mem_pkg::MEM_DATA_WIDTH-1:0]   wr_wdata_o,
  output logic [mem_pkg::MEM_STRB_WIDTH-1:0]   wr_be_o,
  output logic                                 frame_done_o,
  output logic [frame_pkg::FRAME_LEN_WIDTH-1:0] frame_len_o
);

  import mem_pkg::*;
  import frame_pkg::*;

  logic                       accept;
  logic                       word_end;
  logic [MEM_LANE_WIDTH-1:0]  lane_q;
  logic [MEM_STRB_WIDTH-1:0]  mask_q;
  logic [MEM_STRB_WIDTH-1:0]  mask_next;
  logic [MEM_DATA_WIDTH-1:0]  word_q;
  logic [MEM_DATA_WIDTH-1:0]  word_next;
  logic [MEM_ADDR_WIDTH-1:0]  addr_q;
  logic [FRAME_LEN_WIDTH-1:0] count_q;
  logic [FRAME_LEN_WIDTH-1:0] count_next;
  logic                       wr_req_q;
  logic [MEM_DATA_WIDTH-1:0]  wr_wdata_q;
  logic [MEM_STRB_WIDTH-1:0]  wr_be_q;
  logic                       done_q;
  logic [FRAME_LEN_WIDTH-1:0] len_q;

  // Input is held off during the flush cycle and while the reader owns the SRAM
  assign ready_o  = ~(done_q | busy_i);
  assign accept   = byte_valid_i & ready_o;
  // A word is finished when lane 3 fills or the frame ends early
  assign word_end = accept & ((&lane_q) | byte_last_i);

  assign count_next = count_q + 1'b1;

  // Drop the new byte into its lane
  always_comb begin
    word_next = word_q;
    word_next[lane_q*MEM_BYTE_WIDTH +: MEM_BYTE_WIDTH] = byte_data_i;
    mask_next = mask_q;
    mask_next[lane_q] = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lane_q   <= '0;
      mask_q   <= '0;
      addr_q   <= '0;
      count_q  <= '0;
      wr_req_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      wr_req_q <= word_end;
      done_q   <= accept & byte_last_i;
      if (accept) begin
        if (word_end) begin
          lane_q <= '0;
          mask_q <= '0;
        end else begin
          lane_q <= lane_q + 1'b1;
          mask_q <= mask_next;
        end
        count_q <= byte_last_i ? '0 : count_next;
      end
      // Address moves on once the write has gone out
      if (wr_req_q) begin
        addr_q <= done_q ? '0 : addr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      word_q <= word_next;
    end
    if (word_end) begin
      wr_wdata_q <= word_next;
      wr_be_q    <= mask_next;
    end
    if (accept & byte_last_i) begin
      len_q <= count_next;
    end
  end

  assign wr_req_o     = wr_req_q;
  assign wr_addr_o    = addr_q;
  assign wr_wdata_o   = wr_wdata_q;
  assign wr_be_o      = wr_be_q;
  assign frame_done_o = done_q;
  assign frame_len_o  = len_q;

endmodule

/* design/mem_pkg.sv */
/*
 * Memory geometry for the frame buffer
 * Word width, byte lanes and depth of the single-port SRAM
 */
package mem_pkg;

  // One byte lane
  localparam int unsigned MEM_BYTE_WIDTH = 8;

  // Word width and byte lanes per word
  localparam int unsigned MEM_DATA_WIDTH = 32;
  localparam int unsigned MEM_STRB_WIDTH = MEM_DATA_WIDTH / MEM_BYTE_WIDTH;

  // Lane index width inside a word
  localparam int unsigned MEM_LANE_WIDTH = $clog2(MEM_STRB_WIDTH);

  // Storage depth in words
  localparam int unsigned MEM_N_WORDS    = 64;
  localparam int unsigned MEM_ADDR_WIDTH = $clog2(MEM_N_WORDS);

endpackage

/* design/sram.sv */
/*
 * Single-port SRAM, behavioral
 * Byte-lane writes, one cycle read latency
 */
`timescale 1ns/1ps

module sram (
  input  logic                                clk_i,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [mem_pkg::MEM_ADDR_WIDTH-1:0]  addr_i,
  input  logic [mem_pkg::MEM_DATA_WIDTH-1:0]  wdata_i,
  input  logic [mem_pkg::MEM_STRB_WIDTH-1:0]  be_i,
  output logic [mem_pkg::MEM_DATA_WIDTH-1:0]  rdata_o
);

  import mem_pkg::*;

  logic [MEM_DATA_WIDTH-1:0] mem [MEM_N_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Only enabled lanes change
        for (int unsigned i = 0; i < MEM_STRB_WIDTH; i++) begin
          if (be_i[i]) begin
            mem[addr_i][i*MEM_BYTE_WIDTH +: MEM_BYTE_WIDTH] <=
              wdata_i[i*MEM_BYTE_WIDTH +: MEM_BYTE_WIDTH];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule
